/* test/video_board_stimulus.txt */
# W <addr hex> <data hex> is a bus write, P <col> <row> <rgb hex> an expected pixel
# T <n> starts test n, F checks one frame for black rgb and sync timing
T 1
F
T 2
W 085 01
W 000 11
W 009 22
W 040 00
W 049 00
W 211 f0
W 311 05
W 222 3a
W 322 0c
P 1 2 f05
P 6 5 3ac
T 3
W 040 33
W 233 48
W 333 01
W 012 00
W 052 00
W 084 07
W 207 9d
W 307 02
P 2 1 481
P 5 6 3ac
P 9 10 9d2
T 4
W 082 1c
W 083 1e
W 07f 00
P 5 3 481
P 1 1 f05
T 5
W 233 c7
W 333 0e
P 5 3 c7e
P 1 1 f05
T 6
W 085 00
F

/* sources.f */
rtl/video_pkg.sv
rtl/video_timing.sv
rtl/bus_decode.sv
rtl/tilemap_layer.sv
rtl/priority_mixer.sv
rtl/palette_lookup.sv
rtl/video_board.sv
test/video_board_assertions.sv
test/video_board_tb.sv

/* Makefile */
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ns -f sources.f \
		--top-module video_board_tb

sim:
	rm -f $(LOG)
	verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
		-f sources.f --top-module video_board_tb -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/Vvideo_board_tb | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/video_board_tb.sv */
`default_nettype none

module video_board_tb;

	timeunit 1ns;
	timeprecision 1ns;

	// raster set, same values the board uses
	localparam int H_ACTIVE = 32;
	localparam int H_TOTAL = 40;
	localparam int HSYNC_START = 34;
	localparam int HSYNC_WIDTH = 3;
	localparam int V_ACTIVE = 16;
	localparam int V_TOTAL = 20;
	localparam int VSYNC_START = 17;
	localparam int VSYNC_WIDTH = 2;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	// give up after 3 frames
	localparam int WAIT_LIMIT = 3 * FRAME_CYCLES;
	localparam int DRIVE_DELAY = 10;

	logic clk;
	logic reset;
	logic bus_write;
	video_pkg::bus_addr_t bus_addr;
	video_pkg::bus_data_t bus_data;
	video_pkg::rgb_t rgb;
	video_pkg::video_sync_t video_sync;

	// run bookkeeping
	int errors;
	int checks;
	int test_errors;
	int current_test;
	int tests_run;
	int tests_failed;
	logic timed_out;

	// stimulus file fields
	int fd;
	int code;
	int test_num;
	int col;
	int row;
	logic [63:0] tag;
	logic [8*160-1:0] rest_of_line;
	video_pkg::bus_addr_t file_addr;
	video_pkg::bus_data_t file_data;
	video_pkg::rgb_t file_rgb;

	video_board #(
		.H_ACTIVE(H_ACTIVE),
		.H_TOTAL(H_TOTAL),
		.HSYNC_START(HSYNC_START),
		.HSYNC_WIDTH(HSYNC_WIDTH),
		.V_ACTIVE(V_ACTIVE),
		.V_TOTAL(V_TOTAL),
		.VSYNC_START(VSYNC_START),
		.VSYNC_WIDTH(VSYNC_WIDTH)
	) dut (
		.clk(clk),
		.reset(reset),
		.bus_write(bus_write),
		.bus_addr(bus_addr),
		.bus_data(bus_data),
		.rgb(rgb),
		.video_sync(video_sync)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////
	// compare tasks
	////////////////////

	task automatic check_rgb(input video_pkg::rgb_t got, input video_pkg::rgb_t expected,
			input string what);
		checks++;
		if (got !== expected) begin
			$display("Fail at %0t ns: %s got %h expected %h", $time, what, got, expected);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_sync(input video_pkg::video_sync_t got,
			input video_pkg::video_sync_t expected, input string what);
		checks++;
		if (got !== expected) begin
			$display("Fail at %0t ns: %s got %b expected %b", $time, what, got, expected);
			errors++;
			test_errors++;
		end
	endtask

	// sync and blank at a raster position, all active low
	function automatic video_pkg::video_sync_t expected_sync(input int x, input int y);
		video_pkg::video_sync_t s;
		s.hsync_n = !(x >= HSYNC_START && x < HSYNC_START + HSYNC_WIDTH);
		s.vsync_n = !(y >= VSYNC_START && y < VSYNC_START + VSYNC_WIDTH);
		s.hblank_n = (x < H_ACTIVE);
		s.vblank_n = (y < V_ACTIVE);
		return s;
	endfunction

	////////////////////
	// bus and raster
	////////////////////

	task automatic write_bus(input video_pkg::bus_addr_t addr, input video_pkg::bus_data_t data);
		@(posedge clk);
		#DRIVE_DELAY;
		bus_write = 1'b1;
		bus_addr = addr;
		bus_data = data;
		@(posedge clk);
		#DRIVE_DELAY;
		bus_write = 1'b0;
	endtask

	// frame start is the rise of vblank_n, output raster (0,0)
	task automatic wait_frame_start();
		int cycles;
		logic prev_v;
		logic started;
		cycles = 0;
		started = 1'b0;
		prev_v = video_sync.vblank_n;
		while (!started && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
			started = !prev_v && video_sync.vblank_n;
			prev_v = video_sync.vblank_n;
		end
		if (!started) begin
			$display("timeout at %0t ns: no frame start seen within 3 frames", $time);
			timed_out = 1'b1;
			errors++;
			test_errors++;
		end
	endtask

	// columns count while hblank_n is high, rows step on its fall
	task automatic wait_pixel(input int x, input int y);
		int cycles;
		int c;
		int r;
		logic prev_h;
		logic found;
		wait_frame_start();
		cycles = 0;
		c = 0;
		r = 0;
		prev_h = 1'b1;
		found = (x == 0 && y == 0);
		while (!timed_out && !found && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
			if (prev_h && !video_sync.hblank_n && video_sync.vblank_n) begin
				r++;
				c = 0;
			end else if (prev_h && video_sync.hblank_n) begin
				c++;
			end
			found = video_sync.hblank_n && video_sync.vblank_n && c == x && r == y;
			prev_h = video_sync.hblank_n;
		end
		if (!timed_out && !found) begin
			$display("timeout at %0t ns: pixel (%0d,%0d) never reached", $time, x, y);
			timed_out = 1'b1;
			errors++;
			test_errors++;
		end
	endtask

	// one whole frame, black rgb and sync on the parameter periods
	task automatic check_frame();
		int k;
		int x;
		int y;
		wait_frame_start();
		if (!timed_out) begin
			for (k = 0; k < FRAME_CYCLES; k++) begin
				x = k % H_TOTAL;
				y = k / H_TOTAL;
				check_sync(video_sync, expected_sync(x, y),
					$sformatf("sync at raster (%0d,%0d)", x, y));
				check_rgb(rgb, '0, $sformatf("rgb at raster (%0d,%0d)", x, y));
				@(negedge clk);
			end
		end
	endtask

	task automatic finish_test();
		if (current_test != 0) begin
			tests_run++;
			if (test_errors == 0) begin
				$display("test %0d passed", current_test);
			end else begin
				tests_failed++;
				$display("test %0d failed with %0d errors", current_test, test_errors);
			end
		end
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		reset = 1'b1;
		bus_write = 1'b0;
		bus_addr = '0;
		bus_data = '0;
		errors = 0;
		checks = 0;
		test_errors = 0;
		current_test = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		repeat (10) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		fd = $fopen("test/video_board_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file test/video_board_stimulus.txt");
			errors++;
		end else begin
			while (!timed_out && $fscanf(fd, "%s", tag) == 1) begin
				case (tag)
					"#": code = $fgets(rest_of_line, fd);
					"T": begin
						code = $fscanf(fd, "%d", test_num);
						finish_test();
						current_test = test_num;
						test_errors = 0;
					end
					"W": begin
						code = $fscanf(fd, "%h %h", file_addr, file_data);
						write_bus(file_addr, file_data);
					end
					"P": begin
						code = $fscanf(fd, "%d %d %h", col, row, file_rgb);
						wait_pixel(col, row);
						if (!timed_out)
							check_rgb(rgb, file_rgb,
								$sformatf("rgb at pixel (%0d,%0d)", col, row));
					end
					"F": check_frame();
					default: begin
						$display("unknown line tag in the stimulus file");
						errors++;
					end
				endcase
			end
			$fclose(fd);
		end
		finish_test();

		// bound sync checker failures
		if (dut.sync_checks.assert_failures != 0) begin
			$display("the sync checker saw %0d assertion failures",
				dut.sync_checks.assert_failures);
			errors += dut.sync_checks.assert_failures;
		end

		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && checks > 0) begin
			$display("RESULT: PASS");
		end else begin
			if (checks == 0)
				$display("no checks were run");
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* test/video_board_assertions.sv */
`default_nettype none

module video_board_assertions #(
	parameter int H_ACTIVE = 32,
	parameter int H_TOTAL = 40,
	parameter int HSYNC_WIDTH = 3,
	parameter int V_ACTIVE = 16,
	parameter int VSYNC_WIDTH = 2
) (
	input wire logic clk,
	input wire logic reset,
	input wire video_pkg::pixel_x_t pixel_x,
	input wire video_pkg::pixel_y_t pixel_y,
	input wire video_pkg::rgb_t rgb,
	input wire video_pkg::video_sync_t video_sync
);

	timeunit 1ns;
	timeprecision 1ns;

	// vsync spans whole lines
	localparam int VSYNC_CLOCKS = VSYNC_WIDTH * H_TOTAL;
	localparam int DEPTH = video_pkg::PIXEL_PIPE_DEPTH;

	// failed assertions so far
	int assert_failures = 0;

	////////////////////
	// sync pulses
	////////////////////

	hsync_width: assert property (@(posedge clk) disable iff (reset)
		$fell(video_sync.hsync_n) |-> ##HSYNC_WIDTH $rose(video_sync.hsync_n))
		else begin
			assert_failures++;
			$error("hsync low pulse is not %0d clocks wide", HSYNC_WIDTH);
		end

	// one hsync per line
	hsync_period: assert property (@(posedge clk) disable iff (reset)
		$fell(video_sync.hsync_n) |-> ##H_TOTAL $fell(video_sync.hsync_n))
		else begin
			assert_failures++;
			$error("hsync period is not %0d clocks", H_TOTAL);
		end

	vsync_width: assert property (@(posedge clk) disable iff (reset)
		$fell(video_sync.vsync_n) |-> ##VSYNC_CLOCKS $rose(video_sync.vsync_n))
		else begin
			assert_failures++;
			$error("vsync low pulse is not %0d lines wide", VSYNC_WIDTH);
		end

	////////////////////
	// blanking
	////////////////////

	// raster outside the active area shows black after the pipe delay
	rgb_blanked: assert property (@(posedge clk) disable iff (reset)
		($past(pixel_x, DEPTH) >= H_ACTIVE || $past(pixel_y, DEPTH) >= V_ACTIVE)
		|-> (rgb == '0))
		else begin
			assert_failures++;
			$error("rgb is not black during blanking");
		end

endmodule

bind video_board video_board_assertions #(
	.H_ACTIVE(H_ACTIVE),
	.H_TOTAL(H_TOTAL),
	.HSYNC_WIDTH(HSYNC_WIDTH),
	.V_ACTIVE(V_ACTIVE),
	.VSYNC_WIDTH(VSYNC_WIDTH)
) sync_checks (
	.clk(clk),
	.reset(reset),
	.pixel_x(pixel_x),
	.pixel_y(pixel_y),
	.rgb(rgb),
	.video_sync(video_sync)
);

`default_nettype wire

/* rtl/video_board.sv */
`default_nettype none

module video_board #(
	parameter int H_ACTIVE = 32,
	parameter int H_TOTAL = 40,
	parameter int HSYNC_START = 34,
	parameter int HSYNC_WIDTH = 3,
	parameter int V_ACTIVE = 16,
	parameter int V_TOTAL = 20,
	parameter int VSYNC_START = 17,
	parameter int VSYNC_WIDTH = 2,
	parameter int BACK_LAYER_PRIORITY = 0,
	parameter int FRONT_LAYER_PRIORITY = 1,
	parameter logic [1:0] LAYER_DISABLE_MASK = 2'b00
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic bus_write,
	input wire video_pkg::bus_addr_t bus_addr,
	input wire video_pkg::bus_data_t bus_data,
	output wire video_pkg::rgb_t rgb,
	output wire video_pkg::video_sync_t video_sync
);

	// bit 0 back layer, bit 1 front layer
	localparam bit BACK_LAYER_ENABLE = !LAYER_DISABLE_MASK[0];
	localparam bit FRONT_LAYER_ENABLE = !LAYER_DISABLE_MASK[1];

	video_pkg::pixel_x_t pixel_x;
	video_pkg::pixel_y_t pixel_y;
	video_pkg::bus_write_t ram_write;
	video_pkg::scroll_t back_scroll_x;
	video_pkg::scroll_t back_scroll_y;
	video_pkg::scroll_t front_scroll_x;
	video_pkg::scroll_t front_scroll_y;
	video_pkg::color_index_t back_color;
	video_pkg::color_index_t back_index;
	video_pkg::color_index_t front_index;
	video_pkg::color_index_t mixed_index;
	logic display_enable;

	////////////////////
	// timing and bus
	////////////////////

	video_timing #(
		.H_ACTIVE(H_ACTIVE),
		.H_TOTAL(H_TOTAL),
		.HSYNC_START(HSYNC_START),
		.HSYNC_WIDTH(HSYNC_WIDTH),
		.V_ACTIVE(V_ACTIVE),
		.V_TOTAL(V_TOTAL),
		.VSYNC_START(VSYNC_START),
		.VSYNC_WIDTH(VSYNC_WIDTH)
	) video_timing (
		.clk(clk),
		.reset(reset),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.video_sync(video_sync)
	);

	bus_decode bus_decode (
		.clk(clk),
		.reset(reset),
		.bus_write(bus_write),
		.bus_addr(bus_addr),
		.bus_data(bus_data),
		.ram_write(ram_write),
		.back_scroll_x(back_scroll_x),
		.back_scroll_y(back_scroll_y),
		.front_scroll_x(front_scroll_x),
		.front_scroll_y(front_scroll_y),
		.back_color(back_color),
		.display_enable(display_enable)
	);

	////////////////////
	// pixel path
	////////////////////

	// map offset is the low 6 bits of the window
	tilemap_layer #(
		.LAYER_ENABLE(BACK_LAYER_ENABLE)
	) back_layer (
		.clk(clk),
		.map_write(ram_write.back_map),
		.map_offset(ram_write.offset[5:0]),
		.map_data(ram_write.data),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.scroll_x(back_scroll_x),
		.scroll_y(back_scroll_y),
		.color_index(back_index)
	);

	tilemap_layer #(
		.LAYER_ENABLE(FRONT_LAYER_ENABLE)
	) front_layer (
		.clk(clk),
		.map_write(ram_write.front_map),
		.map_offset(ram_write.offset[5:0]),
		.map_data(ram_write.data),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.scroll_x(front_scroll_x),
		.scroll_y(front_scroll_y),
		.color_index(front_index)
	);

	priority_mixer #(
		.BACK_LAYER_PRIORITY(BACK_LAYER_PRIORITY),
		.FRONT_LAYER_PRIORITY(FRONT_LAYER_PRIORITY)
	) priority_mixer (
		.clk(clk),
		.back_index(back_index),
		.front_index(front_index),
		.back_color(back_color),
		.mixed_index(mixed_index)
	);

	// delayed sync doubles as the blanking mask
	palette_lookup palette_lookup (
		.clk(clk),
		.rg_write(ram_write.palette_rg),
		.b_write(ram_write.palette_b),
		.palette_offset(ram_write.offset),
		.palette_data(ram_write.data),
		.mixed_index(mixed_index),
		.video_sync(video_sync),
		.display_enable(display_enable),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

/* rtl/palette_lookup.sv */
`default_nettype none

module palette_lookup (
	input wire logic clk,
	input wire logic rg_write,
	input wire logic b_write,
	input wire video_pkg::color_index_t palette_offset,
	input wire video_pkg::bus_data_t palette_data,
	input wire video_pkg::color_index_t mixed_index,
	input wire video_pkg::video_sync_t video_sync,
	input wire logic display_enable,
	output video_pkg::rgb_t rgb
);

	localparam int ENTRIES = video_pkg::PALETTE_ENTRIES;

	// red high nibble, green low nibble
	logic [7:0] rg_ram [ENTRIES];
	// blue only in the low nibble
	logic [3:0] b_ram [ENTRIES];

	logic [7:0] rg_entry;
	logic [3:0] b_entry;
	logic show_pixel;

	////////////////////
	// palette RAMs
	////////////////////

	always_ff @(posedge clk) begin
		if (rg_write)
			rg_ram[palette_offset] <= palette_data;
	end

	always_ff @(posedge clk) begin
		if (b_write)
			b_ram[palette_offset] <= palette_data[3:0];
	end

	// pipeline stage 3
	always_ff @(posedge clk) begin
		rg_entry <= rg_ram[mixed_index];
		b_entry <= b_ram[mixed_index];
	end

	////////////////////
	// output blanking
	////////////////////

	// sync here is already aligned to stage 3
	assign show_pixel = video_sync.hblank_n && video_sync.vblank_n && display_enable;

	// black outside the active area
	assign rgb = show_pixel ? {rg_entry, b_entry} : '0;

endmodule

`default_nettype wire

/* rtl/priority_mixer.sv */
`default_nettype none

module priority_mixer #(
	parameter int BACK_LAYER_PRIORITY = 0,
	parameter int FRONT_LAYER_PRIORITY = 1
) (
	input wire logic clk,
	input wire video_pkg::color_index_t back_index,
	input wire video_pkg::color_index_t front_index,
	input wire video_pkg::color_index_t back_color,
	output video_pkg::color_index_t mixed_index
);

	// front takes ties
	localparam bit FRONT_ON_TOP = (FRONT_LAYER_PRIORITY >= BACK_LAYER_PRIORITY);

	logic back_opaque;
	logic front_opaque;
	video_pkg::color_index_t mixed_next;

	////////////////////
	// layer select
	////////////////////

	assign back_opaque = (back_index != '0);
	assign front_opaque = (front_index != '0);

	always_comb begin
		if (front_opaque && (FRONT_ON_TOP || !back_opaque))
			mixed_next = front_index;
		else if (back_opaque)
			mixed_next = back_index;
		else
			// both transparent
			mixed_next = back_color;
	end

	// pipeline stage 2
	always_ff @(posedge clk) begin
		mixed_index <= mixed_next;
	end

endmodule

`default_nettype wire

/* rtl/tilemap_layer.sv */
`default_nettype none

module tilemap_layer #(
	parameter bit LAYER_ENABLE = 1'b1
) (
	input wire logic clk,
	input wire logic map_write,
	input wire logic [5:0] map_offset,
	input wire video_pkg::bus_data_t map_data,
	input wire video_pkg::pixel_x_t pixel_x,
	input wire video_pkg::pixel_y_t pixel_y,
	input wire video_pkg::scroll_t scroll_x,
	input wire video_pkg::scroll_t scroll_y,
	output video_pkg::color_index_t color_index
);

	localparam int TILE_BITS = video_pkg::TILE_BITS;
	localparam int MAP_BITS = video_pkg::MAP_BITS;
	// map wraps every 32 pixels
	localparam int COORD_BITS = TILE_BITS + MAP_BITS;

	// scrolled position inside the map
	logic [COORD_BITS-1:0] map_x;
	logic [COORD_BITS-1:0] map_y;
	logic [MAP_BITS-1:0] tile_col;
	logic [MAP_BITS-1:0] tile_row;
	logic [2*MAP_BITS-1:0] tile_addr;

	// flat-colour tiles, entry is the colour
	video_pkg::color_index_t map_ram [video_pkg::MAP_ENTRIES];

	////////////////////
	// scroll and tile select
	////////////////////

	// add wraps naturally at 5 bits
	assign map_x = pixel_x[COORD_BITS-1:0] + scroll_x;
	assign map_y = pixel_y[COORD_BITS-1:0] + scroll_y;

	// drop the in-tile pixel bits
	assign tile_col = map_x[COORD_BITS-1:TILE_BITS];
	assign tile_row = map_y[COORD_BITS-1:TILE_BITS];

	// row-major map, 8 entries per row
	assign tile_addr = {tile_row, tile_col};

	////////////////////
	// map RAM
	////////////////////

	// bus side write port
	always_ff @(posedge clk) begin
		if (map_write)
			map_ram[map_offset] <= map_data;
	end

	// video side read, pipeline stage 1
	always_ff @(posedge clk) begin
		if (LAYER_ENABLE)
			color_index <= map_ram[tile_addr];
		else
			// disabled layer reads as transparent
			color_index <= '0;
	end

endmodule

`default_nettype wire

/* rtl/bus_decode.sv */
`default_nettype none

module bus_decode (
	input wire logic clk,
	input wire logic reset,
	input wire logic bus_write,
	input wire video_pkg::bus_addr_t bus_addr,
	input wire video_pkg::bus_data_t bus_data,
	output video_pkg::bus_write_t ram_write,
	output video_pkg::scroll_t back_scroll_x,
	output video_pkg::scroll_t back_scroll_y,
	output video_pkg::scroll_t front_scroll_x,
	output video_pkg::scroll_t front_scroll_y,
	output video_pkg::color_index_t back_color,
	output logic display_enable
);

	////////////////////
	// RAM window strobes
	////////////////////

	// at most one strobe, addressed RAM writes at next edge
	always_comb begin
		ram_write = '0;
		ram_write.offset = bus_addr[7:0];
		ram_write.data = bus_data;
		if (bus_write) begin
			if (bus_addr >= video_pkg::BACK_MAP_BASE &&
					bus_addr < video_pkg::BACK_MAP_BASE + video_pkg::MAP_ENTRIES)
				ram_write.back_map = 1'b1;
			else if (bus_addr >= video_pkg::FRONT_MAP_BASE &&
					bus_addr < video_pkg::FRONT_MAP_BASE + video_pkg::MAP_ENTRIES)
				ram_write.front_map = 1'b1;
			else if (bus_addr >= video_pkg::PALETTE_RG_BASE &&
					bus_addr < video_pkg::PALETTE_RG_BASE + video_pkg::PALETTE_ENTRIES)
				ram_write.palette_rg = 1'b1;
			else if (bus_addr >= video_pkg::PALETTE_B_BASE &&
					bus_addr < video_pkg::PALETTE_B_BASE + video_pkg::PALETTE_ENTRIES)
				ram_write.palette_b = 1'b1;
		end
	end

	////////////////////
	// control registers
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			back_scroll_x <= '0;
			back_scroll_y <= '0;
			front_scroll_x <= '0;
			front_scroll_y <= '0;
			back_color <= '0;
			display_enable <= 1'b0;
		end else if (bus_write) begin
			// unmapped addresses fall through
			case (bus_addr)
				video_pkg::BACK_SCROLL_X_ADDR: back_scroll_x <= bus_data[4:0];
				video_pkg::BACK_SCROLL_Y_ADDR: back_scroll_y <= bus_data[4:0];
				video_pkg::FRONT_SCROLL_X_ADDR: front_scroll_x <= bus_data[4:0];
				video_pkg::FRONT_SCROLL_Y_ADDR: front_scroll_y <= bus_data[4:0];
				video_pkg::BACK_COLOR_ADDR: back_color <= bus_data;
				video_pkg::DISPLAY_ENABLE_ADDR: display_enable <= bus_data[0];
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/video_timing.sv */
`default_nettype none

module video_timing #(
	parameter int H_ACTIVE = 32,
	parameter int H_TOTAL = 40,
	parameter int HSYNC_START = 34,
	parameter int HSYNC_WIDTH = 3,
	parameter int V_ACTIVE = 16,
	parameter int V_TOTAL = 20,
	parameter int VSYNC_START = 17,
	parameter int VSYNC_WIDTH = 2
) (
	input wire logic clk,
	input wire logic reset,
	output video_pkg::pixel_x_t pixel_x,
	output video_pkg::pixel_y_t pixel_y,
	output video_pkg::video_sync_t video_sync
);

	localparam int DEPTH = video_pkg::PIXEL_PIPE_DEPTH;

	// count limits in counter width
	localparam video_pkg::pixel_x_t H_LAST = video_pkg::pixel_x_t'(H_TOTAL - 1);
	localparam video_pkg::pixel_x_t H_VISIBLE = video_pkg::pixel_x_t'(H_ACTIVE);
	localparam video_pkg::pixel_x_t HSYNC_FIRST = video_pkg::pixel_x_t'(HSYNC_START);
	localparam video_pkg::pixel_x_t HSYNC_LAST =
		video_pkg::pixel_x_t'(HSYNC_START + HSYNC_WIDTH - 1);
	localparam video_pkg::pixel_y_t V_LAST = video_pkg::pixel_y_t'(V_TOTAL - 1);
	localparam video_pkg::pixel_y_t V_VISIBLE = video_pkg::pixel_y_t'(V_ACTIVE);
	localparam video_pkg::pixel_y_t VSYNC_FIRST = video_pkg::pixel_y_t'(VSYNC_START);
	localparam video_pkg::pixel_y_t VSYNC_LAST =
		video_pkg::pixel_y_t'(VSYNC_START + VSYNC_WIDTH - 1);

	logic line_end;
	logic frame_end;
	video_pkg::video_sync_t raw_sync;
	video_pkg::video_sync_t sync_pipe [DEPTH];

	////////////////////
	// raster counters
	////////////////////

	assign line_end = (pixel_x == H_LAST);
	assign frame_end = (pixel_y == V_LAST);

	always_ff @(posedge clk) begin
		if (reset) begin
			pixel_x <= '0;
			pixel_y <= '0;
		end else if (line_end) begin
			pixel_x <= '0;
			// line counter steps once per line
			if (frame_end)
				pixel_y <= '0;
			else
				pixel_y <= pixel_y + 1'b1;
		end else begin
			pixel_x <= pixel_x + 1'b1;
		end
	end

	////////////////////
	// sync and blank decode
	////////////////////

	always_comb begin
		raw_sync.hsync_n = !(pixel_x >= HSYNC_FIRST && pixel_x <= HSYNC_LAST);
		// vsync spans whole lines
		raw_sync.vsync_n = !(pixel_y >= VSYNC_FIRST && pixel_y <= VSYNC_LAST);
		raw_sync.hblank_n = (pixel_x < H_VISIBLE);
		raw_sync.vblank_n = (pixel_y < V_VISIBLE);
	end

	// delay line, matches fetch + mix + palette
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++)
				sync_pipe[i] <= '1;
		end else begin
			sync_pipe[0] <= raw_sync;
			for (int i = 1; i < DEPTH; i++)
				sync_pipe[i] <= sync_pipe[i - 1];
		end
	end

	assign video_sync = sync_pipe[DEPTH - 1];

endmodule

`default_nettype wire

/* rtl/video_pkg.sv */
`default_nettype none

package video_pkg;

	////////////////////
	// vector types
	////////////////////

	// raster position, wide enough for the blanking region
	typedef logic [5:0] pixel_x_t;
	typedef logic [4:0] pixel_y_t;
	// index 0 from a layer is transparent
	typedef logic [7:0] color_index_t;
	// red nibble on top, then green, then blue
	typedef logic [11:0] rgb_t;
	typedef logic [11:0] bus_addr_t;
	typedef logic [7:0] bus_data_t;
	typedef logic [4:0] scroll_t;

	// all active low
	typedef struct packed {
		logic hsync_n;
		logic vsync_n;
		logic hblank_n;
		logic vblank_n;
	} video_sync_t;

	// one strobe per RAM target, offset and data shared
	typedef struct packed {
		logic back_map;
		logic front_map;
		logic palette_rg;
		logic palette_b;
		logic [7:0] offset;
		bus_data_t data;
	} bus_write_t;

	////////////////////
	// register address map
	////////////////////

	localparam bus_addr_t BACK_MAP_BASE = 12'h000;
	localparam bus_addr_t FRONT_MAP_BASE = 12'h040;
	localparam int MAP_ENTRIES = 64;
	localparam bus_addr_t BACK_SCROLL_X_ADDR = 12'h080;
	localparam bus_addr_t BACK_SCROLL_Y_ADDR = 12'h081;
	localparam bus_addr_t FRONT_SCROLL_X_ADDR = 12'h082;
	localparam bus_addr_t FRONT_SCROLL_Y_ADDR = 12'h083;
	localparam bus_addr_t BACK_COLOR_ADDR = 12'h084;
	localparam bus_addr_t DISPLAY_ENABLE_ADDR = 12'h085;
	localparam bus_addr_t PALETTE_RG_BASE = 12'h200;
	localparam bus_addr_t PALETTE_B_BASE = 12'h300;
	localparam int PALETTE_ENTRIES = 256;

	// position to rgb: layer fetch, mixer, palette
	localparam int PIXEL_PIPE_DEPTH = 3;

	// 4x4 pixel tiles, 8x8 tile map
	localparam int TILE_BITS = 2;
	localparam int MAP_BITS = 3;

endpackage

`default_nettype wire
